//--- Bender.yml
package:
  name: jag_serial_io

sources:
  # Package first, then leaf modules, then the top level
  - hdl/jag_io_pkg.sv
  - hdl/edge_flop.sv
  - hdl/ee_save_ram.sv
  - hdl/ee_serial_ctrl.sv
  - hdl/i2s_frame_rx.sv
  - hdl/jag_serial_io.sv
  - target: test
    files:
      - tests/tb_jag_serial_io.sv

//--- hdl/edge_flop.sv
module edge_flop (
	input  logic sys_clk,
	input  logic clk_i,       // Slow clock, rising edge only
	input  logic set_n_i,     // Active low, wins over clear
	input  logic clear_n_i,   // Active low
	input  logic d_i,
	output logic q_o
);

	logic clk_prev = 1'b0;
	logic q_latch  = 1'b0;
	logic clk_rise;

	assign clk_rise = ~clk_prev & clk_i;

	always_ff @(posedge sys_clk) begin
		clk_prev <= clk_i;
		if (!set_n_i) begin
			q_latch <= 1'b1;
		end else if (!clear_n_i) begin
			q_latch <= 1'b0;
		end else if (clk_rise) begin
			q_latch <= d_i;   // Sample on the detected edge
		end
	end

	// New value visible in the edge cycle itself, like the real part
	assign q_o = !set_n_i   ? 1'b1 :
	             !clear_n_i ? 1'b0 :
	             clk_rise   ? d_i  :
	                          q_latch;

endmodule

//--- hdl/ee_save_ram.sv
module ee_save_ram (
	input  logic                 sys_clk,
	input  jag_io_pkg::ee_addr_t addr_i,
	input  jag_io_pkg::ee_word_t wdata_i,
	input  logic                 we_i,
	output jag_io_pkg::ee_word_t rdata_o
);

	import jag_io_pkg::*;

	// Save contents, blank part at power-up
	ee_word_t mem [EE_WORDS];

	initial begin
		for (int i = 0; i < EE_WORDS; i++) begin
			mem[i] = EE_ERASED;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (we_i) begin
			mem[addr_i] <= wdata_i;
		end
		rdata_o <= mem[addr_i];   // Old data on a write cycle
	end

endmodule

//--- hdl/ee_serial_ctrl.sv
module ee_serial_ctrl (
	input  logic                 sys_clk,
	input  logic                 xresetl,
	input  logic                 cs_i,
	input  logic                 sk_i,
	input  logic                 di_i,
	output logic                 do_o,          // Data out, also ready/busy
	output jag_io_pkg::ee_addr_t mem_addr_o,
	output jag_io_pkg::ee_word_t mem_wdata_o,
	output logic                 mem_we_o,
	input  jag_io_pkg::ee_word_t mem_rdata_i
);

	import jag_io_pkg::*;

	ee_state_e state;
	ee_instr_t ir;            // Instruction shift register
	ee_cnt_t   cnt;           // Data bit counter
	ee_word_t  dr;            // Data in, or read word going out
	ee_addr_t  wr_addr;       // Address of the internal write
	ee_word_t  wr_data;
	logic      wr_loop;       // WRAL/ERAL walk the whole array
	logic      ewen;          // Write enable flag, survives CS low
	logic      sk_prev;
	logic      sk_rise;
	logic      dout_q;
	logic      we_q;
	logic      erase_kind;    // ERASE or ERAL, data forced blank

	assign sk_rise = ~sk_prev & sk_i;

	// ir already shifted at this point, opcode in [7:6]
	assign erase_kind = (ir[7:6] == EE_OP_ERASE) ||
	                    ((ir[7:6] == EE_OP_EXT) && (ir[5:4] == EE_EXT_ERAL));

	assign do_o        = dout_q;
	assign mem_we_o    = we_q;
	assign mem_wdata_o = wr_data;

	// Outside the write states the RAM sees the address still coming in,
	// so the read word is ready on the completing edge
	assign mem_addr_o = state[2] ? wr_addr : {ir[4:0], di_i};

	always_ff @(posedge sys_clk) begin
		sk_prev <= sk_i;
		we_q    <= 1'b0;   // Single cycle strobe
		if (!xresetl) begin
			state   <= EE_IDLE;
			ir      <= '0;
			cnt     <= '0;
			dout_q  <= 1'b1;   // Ready
			wr_loop <= 1'b0;
			ewen    <= 1'b0;
		end else if (!cs_i) begin
			// Deselect aborts whatever is going on
			state   <= EE_IDLE;
			ir      <= '0;
			cnt     <= '0;
			dout_q  <= 1'b1;
			wr_loop <= 1'b0;
		end else if (state[2]) begin
			// Internal write sequence, runs off sys_clk alone
			case (state)
				EE_WR_BEGIN: begin
					dout_q  <= 1'b0;   // Busy
					wr_loop <= (ir[7:6] == EE_OP_EXT);
					wr_addr <= (ir[7:6] == EE_OP_EXT) ? '0 : ir[5:0];
					wr_data <= erase_kind ? EE_ERASED : dr;
					state   <= EE_WR_WRITE;
				end
				EE_WR_WRITE: begin
					we_q  <= ewen;   // Locked part runs the sequence but keeps data
					state <= EE_WR_LOOP;
				end
				EE_WR_LOOP: begin
					if (!wr_loop || (wr_addr == '1)) begin
						state <= EE_WR_END;
					end else begin
						wr_addr <= wr_addr + 1'b1;   // RAM still takes the old address
						state   <= EE_WR_WRITE;
					end
				end
				EE_WR_END: begin
					dout_q <= 1'b1;   // Ready again
					state  <= EE_IDLE;
				end
				default: state <= EE_IDLE;
			endcase
		end else if (sk_rise) begin
			case (state)
				EE_IDLE: begin
					ir <= {ir[7:0], di_i};
					// Start bit reached ir[7], this edge brings the last address bit
					if (ir[7]) begin
						case (ir[6:5])
							EE_OP_READ: begin
								dr     <= mem_rdata_i;
								dout_q <= 1'b0;   // Dummy bit
								state  <= EE_READ;
							end
							EE_OP_WRITE: state <= EE_DATA;
							EE_OP_ERASE: state <= EE_WR_BEGIN;
							EE_OP_EXT: begin
								case (ir[4:3])
									EE_EXT_EWDS: ewen  <= 1'b0;
									EE_EXT_WRAL: state <= EE_DATA;
									EE_EXT_ERAL: state <= EE_WR_BEGIN;
									EE_EXT_EWEN: ewen  <= 1'b1;
								endcase
							end
						endcase
					end
				end
				EE_DATA: begin
					dr  <= {dr[14:0], di_i};   // MSB first
					cnt <= cnt + 1'b1;
					if (cnt == '1) begin
						state <= EE_WR_BEGIN;   // 16th bit in
					end
				end
				EE_READ: begin
					dout_q <= dr[15];
					dr     <= {dr[14:0], 1'b0};   // Zeros after the word
				end
				default: state <= EE_IDLE;
			endcase
		end
	end

endmodule

//--- hdl/i2s_frame_rx.sv
module i2s_frame_rx (
	input  logic                      sys_clk,
	input  logic                      xresetl,
	input  logic                      sck_i,
	input  logic                      ws_i,      // Low is left, high is right
	input  logic                      sd_i,
	output jag_io_pkg::audio_sample_t left_o,
	output jag_io_pkg::audio_sample_t right_o
);

	import jag_io_pkg::*;

	audio_sample_t cap_buf [2];   // Words being captured, index by side
	i2s_cnt_t      bit_cnt;
	logic          sck_prev;
	logic          ws_prev;       // WS seen at the last falling edge
	logic          side;          // Channel of the current slot
	logic          frame_next;    // WS changed, resync on next rise
	logic          sck_fall;
	logic          sck_rise;

	assign sck_fall = sck_prev & ~sck_i;
	assign sck_rise = ~sck_prev & sck_i;

	always_ff @(posedge sys_clk) begin
		sck_prev <= sck_i;
		if (!xresetl) begin
			ws_prev    <= ws_i;
			side       <= ws_i;
			frame_next <= 1'b0;
			bit_cnt    <= 5'h10;   // Nothing captured before the first sync
			left_o     <= '0;
			right_o    <= '0;
		end else begin
			// Data valid on the falling edge
			if (sck_fall) begin
				if (!bit_cnt[4]) begin   // Bits past 16 dropped
					bit_cnt <= bit_cnt + 1'b1;
					cap_buf[side][4'd15 - bit_cnt[3:0]] <= sd_i;
				end
				ws_prev <= ws_i;
				if (ws_prev != ws_i) begin
					frame_next <= 1'b1;
				end
			end

			// Slot start on the rising edge after a WS change
			if (sck_rise && frame_next) begin
				bit_cnt    <= '0;
				side       <= ws_i;
				frame_next <= 1'b0;
				if (!ws_i) begin
					// New frame, publish the previous one as a pair
					left_o     <= cap_buf[0];
					right_o    <= cap_buf[1];
					cap_buf[0] <= '0;
					cap_buf[1] <= '0;
				end
			end
		end
	end

endmodule

//--- hdl/jag_io_pkg.sv
package jag_io_pkg;

	// EEPROM geometry, 93C46 in 16-bit mode
	typedef logic [15:0] ee_word_t;    // One data word
	typedef logic [5:0]  ee_addr_t;    // Word address
	typedef logic [8:0]  ee_instr_t;   // Start bit, opcode, address
	typedef logic [3:0]  ee_cnt_t;     // Data bits taken during a write

	// Top bit set means the internal write sequence owns the RAM
	typedef enum logic [2:0] {
		EE_IDLE     = 3'b000,   // Waiting for start bit and instruction
		EE_DATA     = 3'b001,   // Taking 16 data bits
		EE_READ     = 3'b010,   // Shifting the word out
		EE_WR_BEGIN = 3'b100,
		EE_WR_WRITE = 3'b101,
		EE_WR_LOOP  = 3'b110,
		EE_WR_END   = 3'b111
	} ee_state_e;

	// Audio path
	typedef logic [15:0] audio_sample_t;
	typedef logic [4:0]  i2s_cnt_t;    // Bit 4 set once the slot is full

	localparam int       EE_WORDS  = 64;
	localparam ee_word_t EE_ERASED = 16'hFFFF;

	// Opcodes, the two bits after the start bit
	localparam logic [1:0] EE_OP_READ  = 2'b10;
	localparam logic [1:0] EE_OP_WRITE = 2'b01;
	localparam logic [1:0] EE_OP_ERASE = 2'b11;
	localparam logic [1:0] EE_OP_EXT   = 2'b00;   // Sub-code in the top address bits

	// Extended sub-codes
	localparam logic [1:0] EE_EXT_EWDS = 2'b00;   // Write disable
	localparam logic [1:0] EE_EXT_WRAL = 2'b01;   // Write all
	localparam logic [1:0] EE_EXT_ERAL = 2'b10;   // Erase all
	localparam logic [1:0] EE_EXT_EWEN = 2'b11;   // Write enable

endpackage

//--- hdl/jag_serial_io.sv
module jag_serial_io (
	input  logic                      sys_clk,
	input  logic                      xresetl,
	input  logic                      ee_cs_i,
	input  logic                      ee_sk_i,
	input  logic                      ee_di_i,
	output logic                      ee_do_o,
	input  logic                      mute_clk_i,
	input  logic                      mute_d_i,     // 1 means sound on
	input  logic                      i2s_sck_i,
	input  logic                      i2s_ws_i,
	input  logic                      i2s_sd_i,
	output jag_io_pkg::audio_sample_t aud_l_o,
	output jag_io_pkg::audio_sample_t aud_r_o
);

	import jag_io_pkg::*;

	ee_addr_t mem_addr;
	ee_word_t mem_wdata;
	ee_word_t mem_rdata;
	logic     mem_we;
	logic     sound_on;     // Mute latch, low after reset
	logic     ws_clear_n;
	logic     ws_q;         // WS retimed to SCK rise

	// Serial EEPROM with its own save store
	ee_serial_ctrl u_ee_ctrl (
		.sys_clk     (sys_clk),
		.xresetl     (xresetl),
		.cs_i        (ee_cs_i),
		.sk_i        (ee_sk_i),
		.di_i        (ee_di_i),
		.do_o        (ee_do_o),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata),
		.mem_we_o    (mem_we),
		.mem_rdata_i (mem_rdata)
	);

	ee_save_ram u_ee_ram (
		.sys_clk (sys_clk),
		.addr_i  (mem_addr),
		.wdata_i (mem_wdata),
		.we_i    (mem_we),
		.rdata_o (mem_rdata)
	);

	edge_flop mute_ff (
		.sys_clk   (sys_clk),
		.clk_i     (mute_clk_i),
		.set_n_i   (1'b1),
		.clear_n_i (xresetl),   // Muted out of reset
		.d_i       (mute_d_i),
		.q_o       (sound_on)
	);

	// Muted holds WS low, so no frame ever starts
	assign ws_clear_n = sound_on & xresetl;

	edge_flop ws_ff (
		.sys_clk   (sys_clk),
		.clk_i     (i2s_sck_i),
		.set_n_i   (1'b1),
		.clear_n_i (ws_clear_n),
		.d_i       (i2s_ws_i),
		.q_o       (ws_q)
	);

	i2s_frame_rx u_i2s_rx (
		.sys_clk (sys_clk),
		.xresetl (xresetl),
		.sck_i   (i2s_sck_i),
		.ws_i    (ws_q),
		.sd_i    (i2s_sd_i),
		.left_o  (aud_l_o),
		.right_o (aud_r_o)
	);

endmodule

//--- jag_serial_io.f
hdl/jag_io_pkg.sv
hdl/edge_flop.sv
hdl/ee_save_ram.sv
hdl/ee_serial_ctrl.sv
hdl/i2s_frame_rx.sv
hdl/jag_serial_io.sv
tests/tb_jag_serial_io.sv

//--- tests/tb_jag_serial_io.sv
module tb_jag_serial_io;

	timeunit 1ns;
	timeprecision 100ps;

	import jag_io_pkg::*;

	localparam int NUM_WRITES   = 4;
	localparam int MUTED_FRAMES = 3;
	localparam int LIVE_FRAMES  = 8;

	logic          sys_clk;
	logic          xresetl;
	logic          ee_cs;
	logic          ee_sk;
	logic          ee_di;
	logic          ee_do;
	logic          mute_clk;
	logic          mute_d;
	logic          i2s_sck;
	logic          i2s_ws;
	logic          i2s_sd;
	audio_sample_t aud_l;
	audio_sample_t aud_r;

	logic [15:0]   lfsr_state;
	ee_word_t      shadow [EE_WORDS];   // Expected EEPROM contents
	logic          shadow_ewen;
	logic [31:0]   aud_prev;            // Last frame sent, {left, right}
	logic [31:0]   aud_hold;            // Pair the outputs sit at
	ee_addr_t      addrs [NUM_WRITES];
	ee_word_t      word;
	logic [31:0]   exp_pair;
	audio_sample_t smp_l;
	audio_sample_t smp_r;

	jag_serial_io dut (
		.sys_clk    (sys_clk),
		.xresetl    (xresetl),
		.ee_cs_i    (ee_cs),
		.ee_sk_i    (ee_sk),
		.ee_di_i    (ee_di),
		.ee_do_o    (ee_do),
		.mute_clk_i (mute_clk),
		.mute_d_i   (mute_d),
		.i2s_sck_i  (i2s_sck),
		.i2s_ws_i   (i2s_ws),
		.i2s_sd_i   (i2s_sd),
		.aud_l_o    (aud_l),
		.aud_r_o    (aud_r)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#4 sys_clk = ~sys_clk;   // 8 ns period
		end
	end

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// n fresh bits with one step per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[14:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Applies one instruction to the shadow copy, returns the word at addr
	function automatic ee_word_t ee_ref(input logic [1:0] op, input ee_addr_t addr,
			input ee_word_t data);
		if (op == EE_OP_WRITE && shadow_ewen) begin
			shadow[addr] = data;
		end else if (op == EE_OP_ERASE && shadow_ewen) begin
			shadow[addr] = EE_ERASED;
		end else if (op == EE_OP_EXT) begin
			case (addr[5:4])
				EE_EXT_EWDS: shadow_ewen = 1'b0;
				EE_EXT_EWEN: shadow_ewen = 1'b1;
				default: begin
					// WRAL or ERAL over the whole array
					for (int i = 0; i < EE_WORDS; i++) begin
						if (shadow_ewen) begin
							shadow[i] = (addr[5:4] == EE_EXT_WRAL) ? data : EE_ERASED;
						end
					end
				end
			endcase
		end
		return shadow[addr];
	endfunction

	// Pair due at a frame start; muted means nothing moves
	function automatic logic [31:0] audio_ref(input logic sound_on, input logic [31:0] pair);
		logic [31:0] e;
		e = sound_on ? aud_prev : aud_hold;
		if (sound_on) begin
			aud_prev = pair;
		end
		aud_hold = e;
		return e;
	endfunction

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			fail_stop($sformatf("MISMATCH at %0d ns: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	// n clocks and then 1 ns past the edge
	task automatic step(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	// Polls dout on falling edges
	task automatic wait_dout(input logic lvl, input int limit, input string what);
		int n;
		n = 0;
		while (ee_do !== lvl) begin
			@(negedge sys_clk);
			n++;
			if (n > limit) begin
				fail_stop($sformatf("Timeout: ee_do_o never went %s", what));
			end
		end
	endtask

	task automatic sk_bit(input logic b);
		ee_di = b;
		ee_sk = 1'b0;
		step(4);
		ee_sk = 1'b1;   // Part takes di here
		step(4);
	endtask

	task automatic ee_deselect();
		ee_cs = 1'b0;
		ee_sk = 1'b0;
		ee_di = 1'b0;
		step(4);
	endtask

	// Final bit of a write kind followed by the internal sequence
	task automatic last_bit_busy(input logic b, input int limit);
		ee_di = b;
		ee_sk = 1'b0;
		step(4);
		ee_sk = 1'b1;
		wait_dout(1'b0, 10, "busy after the last bit");
		wait_dout(1'b1, limit, "ready after the write sequence");
		step(2);
	endtask

	// Everything but READ; data bits only for WRITE and WRAL
	task automatic ee_cmd(input logic [1:0] op, input ee_addr_t addr, input ee_word_t data);
		logic        ext;
		logic        takes_data;
		logic        runs_seq;
		logic        bulk;
		logic [24:0] seq;
		int          nbits;
		ext        = (op == EE_OP_EXT);
		bulk       = ext && (addr[5:4] == EE_EXT_WRAL || addr[5:4] == EE_EXT_ERAL);
		takes_data = (op == EE_OP_WRITE) || (ext && addr[5:4] == EE_EXT_WRAL);
		runs_seq   = (op == EE_OP_WRITE) || (op == EE_OP_ERASE) || bulk;
		seq        = {1'b1, op, addr, data};
		nbits      = takes_data ? 25 : 9;
		ee_cs = 1'b1;
		step(4);
		for (int i = 24; i > 25 - nbits; i--) begin
			sk_bit(seq[i]);
		end
		if (runs_seq) begin
			last_bit_busy(seq[25 - nbits], bulk ? 400 : 20);   // ~3 cycles per word
		end else begin
			sk_bit(seq[25 - nbits]);
		end
		ee_deselect();
		void'(ee_ref(op, addr, data));
	endtask

	// READ gives a dummy 0 on the address edge and then 16 bits MSB first
	task automatic ee_read_check(input ee_addr_t addr);
		logic [8:0] hdr;
		ee_word_t   got;
		hdr = {1'b1, EE_OP_READ, addr};
		ee_cs = 1'b1;
		step(4);
		for (int i = 8; i >= 0; i--) begin
			sk_bit(hdr[i]);
		end
		check_eq("ee_do_o dummy bit", ee_do, 32'd0);
		got = '0;
		for (int i = 0; i < 16; i++) begin
			sk_bit(1'b0);
			got = {got[14:0], ee_do};
		end
		ee_deselect();
		check_eq($sformatf("ee_do_o word at %0d", addr), got, ee_ref(EE_OP_READ, addr, '0));
	endtask

	// Written addresses plus both ends of the array
	task automatic read_sampled();
		for (int k = 0; k < NUM_WRITES; k++) begin
			ee_read_check(addrs[k]);
		end
		ee_read_check(6'd0);
		ee_read_check(6'd63);
	endtask

	// 24 SCK periods with WS at the first rise and the MSB on the next
	task automatic i2s_slot(input logic ws, input audio_sample_t w);
		for (int c = 0; c < 24; c++) begin
			i2s_sck = 1'b1;
			i2s_ws  = ws;
			i2s_sd  = (c >= 1 && c <= 16) ? w[16 - c] : 1'b0;
			step(4);
			i2s_sck = 1'b0;   // Receiver captures here
			step(4);
		end
	endtask

	// Left slot carries the frame start and the outputs are checked after it
	task automatic frame_check(input logic sound_on, input logic do_check, input logic send_right);
		smp_l    = rand_bits(16);
		smp_r    = rand_bits(16);
		exp_pair = audio_ref(sound_on, {smp_l, smp_r});
		i2s_slot(1'b0, smp_l);
		if (do_check) begin
			check_eq("aud_l_o", aud_l, exp_pair[31:16]);
			check_eq("aud_r_o", aud_r, exp_pair[15:0]);
		end
		if (send_right) begin
			i2s_slot(1'b1, smp_r);
		end
	endtask

	initial begin
		xresetl     = 1'b0;
		ee_cs       = 1'b0;
		ee_sk       = 1'b0;
		ee_di       = 1'b0;
		mute_clk    = 1'b0;
		mute_d      = 1'b0;
		i2s_sck     = 1'b0;
		i2s_ws      = 1'b0;
		i2s_sd      = 1'b0;
		lfsr_state  = 16'd10841;
		shadow_ewen = 1'b0;
		aud_prev    = '0;
		aud_hold    = '0;
		for (int i = 0; i < EE_WORDS; i++) begin
			shadow[i] = EE_ERASED;   // Blank part
		end
		step(3);
		xresetl = 1'b1;
		step(2);

		// Idle levels out of reset
		check_eq("ee_do_o", ee_do, 32'd1);
		check_eq("aud_l_o", aud_l, 32'd0);
		check_eq("aud_r_o", aud_r, 32'd0);

		// EWEN, random writes, read back
		ee_cmd(EE_OP_EXT, {EE_EXT_EWEN, 4'h0}, '0);
		for (int k = 0; k < NUM_WRITES; k++) begin
			word     = rand_bits(6);
			addrs[k] = word[5:0];
			ee_cmd(EE_OP_WRITE, addrs[k], rand_bits(16));
		end
		for (int k = 0; k < NUM_WRITES; k++) begin
			ee_read_check(addrs[k]);
		end

		// Locked part runs the sequence but keeps its data
		ee_cmd(EE_OP_EXT, {EE_EXT_EWDS, 4'h0}, '0);
		ee_cmd(EE_OP_WRITE, addrs[0], rand_bits(16));
		ee_cmd(EE_OP_ERASE, addrs[1], '0);
		ee_read_check(addrs[0]);
		ee_read_check(addrs[1]);

		// ERASE, WRAL, ERAL with writes enabled again
		ee_cmd(EE_OP_EXT, {EE_EXT_EWEN, 4'h0}, '0);
		ee_cmd(EE_OP_ERASE, addrs[0], '0);
		ee_read_check(addrs[0]);
		ee_cmd(EE_OP_EXT, {EE_EXT_WRAL, 4'h0}, rand_bits(16));
		read_sampled();
		ee_cmd(EE_OP_EXT, {EE_EXT_ERAL, 4'h0}, '0);
		read_sampled();

		// WS held low while muted so nothing is published
		for (int f = 0; f < MUTED_FRAMES; f++) begin
			frame_check(1'b0, 1'b1, 1'b1);
		end

		// Sound on
		mute_d   = 1'b1;
		mute_clk = 1'b1;
		step(4);
		mute_clk = 1'b0;
		step(4);

		// The first left slot has no WS change ahead of it and is never captured
		// The last pass only publishes the final frame
		for (int f = 0; f <= LIVE_FRAMES; f++) begin
			frame_check(1'b1, f >= 2, f < LIVE_FRAMES);
		end

		$display("** PASS **");
		$finish;
	end

endmodule
